// ==== files.f ====
+incdir+design
+incdir+dv
design/vramGeomPkg.sv
design/memBusPkg.sv
design/memCmdIf.sv
design/edgeMaskGen.sv
design/windowRotator.sv
design/blockFetcher.sv
design/copySequencer.sv
design/copyTop.sv
dv/tb_copyTop.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the copy engine testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_copyTop -o simCopy
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

simOut=$(./obj_dir/simCopy)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if echo "$simOut" | grep -qF 'All tests passed!'; then
	exit 0
fi
exit 1

// ==== dv/copyTests.svh ====
// Directed copy tests, included inside the testbench module
// Each task runs its copies, checks the memory and prints one result line

// Both corners on block boundaries
task automatic alignedCopyTest();
	int errs;
	errs       = errorCount;
	busyPct    = 0;
	maxLatency = 2;
	runCopy(10'd32, 9'd4, 10'd256, 9'd100, 11'd48, 10'd3, 1'b0);
	reportTest("aligned copy", errs);
endtask

// Destination offset 9, source offset 3
task automatic dstAheadTest();
	int errs;
	errs       = errorCount;
	busyPct    = 20;
	maxLatency = 3;
	runCopy(10'd3, 9'd10, 10'd521, 9'd120, 11'd70, 10'd5, 1'b0);
	reportTest("destination offset ahead", errs);
endtask

// Double load lines, then copies narrower than a block
task automatic dstBehindTest();
	int errs;
	errs       = errorCount;
	busyPct    = 20;
	maxLatency = 3;
	runCopy(10'd76, 9'd20, 10'd613, 9'd140, 11'd100, 10'd3, 1'b0);
	runCopy(10'd202, 9'd30, 10'd708, 9'd160, 11'd5, 10'd2, 1'b0);    // Inside one block
	runCopy(10'd301, 9'd32, 10'd842, 9'd170, 11'd12, 10'd2, 1'b0);   // Straddles two
	reportTest("destination offset behind", errs);
endtask

// Fill pattern gives mixed mask bits in the source
task automatic forceMaskTest();
	int errs;
	errs       = errorCount;
	busyPct    = 10;
	maxLatency = 2;
	runCopy(10'd150, 9'd40, 10'd407, 9'd180, 11'd37, 10'd2, 1'b1);
	reportTest("forced mask bit", errs);
endtask

// Sources in lines 0 to 203, destinations from line 256, so never overlapping
task automatic randomCopyTest();
	int errs;
	errs       = errorCount;
	busyPct    = 60;
	maxLatency = 8;
	for (int n = 0; n < 8; n++) begin
		runCopy(vramX_t'($urandom_range(1023)), vramY_t'($urandom_range(199)),
			vramX_t'($urandom_range(1023)), vramY_t'(256 + $urandom_range(240)),
			sizeW_t'(1 + $urandom_range(159)), sizeH_t'(1 + $urandom_range(4)), 1'b0);
	end
	reportTest("random rectangles", errs);
endtask

// Reset taken in the middle of a copy, then ack held while the request stays high
task automatic handshakeTest();
	int errs;
	errs    = errorCount;
	busyPct = 100;  // Port never takes a command
	@(negedge i_clk);
	i_copyReq = 1'b1;
	repeat (4) @(negedge i_clk);
	checkCommand(1'b1);
	applyReset();
	checkAck(1'b0);
	checkCommand(1'b0);
	busyPct    = 10;
	maxLatency = 1;
	startCopy(10'd500, 9'd60, 10'd20, 9'd200, 11'd20, 10'd2, 1'b0);
	repeat (5) begin
		@(negedge i_clk);
		checkAck(1'b1);
		checkCommand(1'b0);
	end
	finishCopy();
	runCopy(10'd640, 9'd62, 10'd90, 9'd210, 11'd33, 10'd2, 1'b0);  // Second request
	reportTest("start handshake", errs);
endtask

// ==== dv/tb_copyTop.sv ====
// Testbench for the VRAM rectangle copy engine
// Block memory model with random busy and read latency, checks and the test sequence

`include "copy_params.svh"

module tb_copyTop import vramGeomPkg::*, memBusPkg::*; ();

	localparam int ClkPeriod   = 100;
	localparam int NumTests    = 6;
	localparam int PixelBudget = 12000;  // Upper bound over all copies
	localparam int WatchCycles = NumTests * 20000 + PixelBudget * 8;

	logic     i_clk;
	logic     i_rst;
	vramX_t   i_srcX, i_dstX;
	vramY_t   i_srcY, i_dstY;
	sizeW_t   i_sizeW;
	sizeH_t   i_sizeH;
	logic     i_forceMask, i_copyReq, o_copyAck;
	logic     o_command, o_write;
	memAdr_t  o_adr;
	pixMask_t o_writeMask;
	block_t   o_dataOut;
	logic     i_busy = 1'b0;
	logic     i_dataInValid = 1'b0;
	logic [`BLOCK_BITS-1:0] i_dataIn = '0;

	block_t memModel[memAdr_t];  // Blocks written by the DUT
	block_t expMem[memAdr_t];    // Expected contents
	block_t readData;
	int     busyPct, maxLatency;
	int     readWait = 0;
	int     errorCount, testCount, failCount;

	copyTop i_dut (.*);

	initial begin
		i_clk = 1'b0;
		forever #(ClkPeriod / 2) i_clk = ~i_clk;
	end

	// ----------------------------------------
	// Memory model
	// ----------------------------------------

	// Every pixel depends on the whole address
	function automatic block_t fillBlock(memAdr_t adr);
		block_t      blk;
		logic [31:0] h;
		for (int p = 0; p < `PIXELS_PER_BLOCK; p++) begin
			h      = (32'(adr) + 32'd1) * 32'h9e3779b1 + 32'(p) * 32'h7f4a7c15;
			blk[p] = h[31:16] ^ h[15:0];
		end
		return blk;
	endfunction

	function automatic block_t modelBlock(memAdr_t adr);
		return memModel.exists(adr) ? memModel[adr] : fillBlock(adr);
	endfunction

	function automatic block_t expBlock(memAdr_t adr);
		return expMem.exists(adr) ? expMem[adr] : fillBlock(adr);
	endfunction

	// Accepted now means taken at the next rising edge
	always @(negedge i_clk) begin
		block_t blk;
		i_dataInValid = 1'b0;
		if (i_rst) begin
			i_busy   = 1'b0;
			readWait = 0;
		end else begin
			if (readWait > 0) begin
				readWait--;
				if (readWait == 0) begin
					i_dataIn      = readData;
					i_dataInValid = 1'b1;
				end
			end
			i_busy = ($urandom_range(99) < busyPct);
			if (o_command && !i_busy) begin
				if (o_write) begin
					blk = modelBlock(o_adr);
					for (int p = 0; p < `PIXELS_PER_BLOCK; p++)
						if (o_writeMask[p])
							blk[p] = o_dataOut[p];
					memModel[o_adr] = blk;
				end else begin
					readData = modelBlock(o_adr);
					readWait = 1 + $urandom_range(maxLatency);  // At least one cycle
				end
			end
		end
	end

	// ----------------------------------------
	// Checks
	// ----------------------------------------
	task automatic checkBlock(memAdr_t adr, block_t expBlk);
		block_t got;
		got = modelBlock(adr);
		if (got !== expBlk) begin
			errorCount++;
			$display("mismatch at time %0t: block %h holds %h, expected %h",
				$time, adr, got, expBlk);
		end
	endtask

	task automatic checkAck(logic expAck);
		if (o_copyAck !== expAck) begin
			errorCount++;
			$display("mismatch at time %0t: o_copyAck is %b, expected %b",
				$time, o_copyAck, expAck);
		end
	endtask

	task automatic checkCommand(logic expCmd);
		if (o_command !== expCmd) begin
			errorCount++;
			$display("mismatch at time %0t: o_command is %b, expected %b",
				$time, o_command, expCmd);
		end
	endtask

	// Every block touched by either side
	task automatic checkMemory();
		memAdr_t adr;
		if (memModel.first(adr) != 0) begin
			do
				checkBlock(adr, expBlock(adr));
			while (memModel.next(adr) != 0);
		end
		if (expMem.first(adr) != 0) begin
			do
				checkBlock(adr, expBlock(adr));
			while (expMem.next(adr) != 0);
		end
	endtask

	// ----------------------------------------
	// Copy driving
	// ----------------------------------------

	// Destination pixel (x1+k, y1+j) takes source pixel (x0+k, y0+j)
	task automatic expectCopy(vramX_t x0, vramY_t y0, vramX_t x1, vramY_t y1,
			sizeW_t w, sizeH_t h, logic forceBit);
		vramX_t sx, dx;
		vramY_t sy, dy;
		block_t srcBlk, dstBlk;
		for (int j = 0; j < int'(h); j++) begin
			sy = y0 + vramY_t'(j);
			dy = y1 + vramY_t'(j);
			for (int k = 0; k < int'(w); k++) begin
				sx = x0 + vramX_t'(k);  // Wraps at the line end
				dx = x1 + vramX_t'(k);
				srcBlk = expBlock({sy, sx[$bits(vramX_t)-1:`BLOCK_IDX_BITS]});
				dstBlk = expBlock({dy, dx[$bits(vramX_t)-1:`BLOCK_IDX_BITS]});
				dstBlk[dx[`BLOCK_IDX_BITS-1:0]] = srcBlk[sx[`BLOCK_IDX_BITS-1:0]];
				dstBlk[dx[`BLOCK_IDX_BITS-1:0]].maskBit =
					srcBlk[sx[`BLOCK_IDX_BITS-1:0]].maskBit | forceBit;
				expMem[{dy, dx[$bits(vramX_t)-1:`BLOCK_IDX_BITS]}] = dstBlk;
			end
		end
	endtask

	task automatic startCopy(vramX_t x0, vramY_t y0, vramX_t x1, vramY_t y1,
			sizeW_t w, sizeH_t h, logic forceBit);
		int waitCycles;
		int limit;
		expectCopy(x0, y0, x1, y1, w, h, forceBit);
		limit = 64 * (int'(w) / `PIXELS_PER_BLOCK + 3) * int'(h) + 100;
		@(negedge i_clk);
		i_srcX      = x0;
		i_srcY      = y0;
		i_dstX      = x1;
		i_dstY      = y1;
		i_sizeW     = w;
		i_sizeH     = h;
		i_forceMask = forceBit;
		i_copyReq   = 1'b1;
		waitCycles  = 0;
		while (!o_copyAck && waitCycles < limit) begin
			@(negedge i_clk);
			waitCycles++;
		end
		if (!o_copyAck) begin
			errorCount++;
			$display("copy from (%0d,%0d) to (%0d,%0d) never raised o_copyAck",
				x0, y0, x1, y1);
		end
	endtask

	// Ack must fall one cycle after the request drops
	task automatic finishCopy();
		i_copyReq = 1'b0;
		@(negedge i_clk);
		checkAck(1'b0);
		checkMemory();
	endtask

	task automatic runCopy(vramX_t x0, vramY_t y0, vramX_t x1, vramY_t y1,
			sizeW_t w, sizeH_t h, logic forceBit);
		startCopy(x0, y0, x1, y1, w, h, forceBit);
		finishCopy();
	endtask

	task automatic applyReset();
		@(negedge i_clk);
		i_rst     = 1'b1;
		i_copyReq = 1'b0;
		repeat (16) @(negedge i_clk);
		i_rst = 1'b0;
	endtask

	task automatic reportTest(string name, int errorsBefore);
		testCount++;
		if (errorCount == errorsBefore) begin
			$display("%s: ok", name);
		end else begin
			failCount++;
			$display("%s: %0d errors", name, errorCount - errorsBefore);
		end
	endtask

	`include "copyTests.svh"

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------
	initial begin
		void'($urandom(32'h9f9049f4));
		i_rst       = 1'b1;
		i_copyReq   = 1'b0;
		i_forceMask = 1'b0;
		i_srcX      = '0;
		i_srcY      = '0;
		i_dstX      = '0;
		i_dstY      = '0;
		i_sizeW     = sizeW_t'(1);
		i_sizeH     = sizeH_t'(1);
		busyPct     = 0;
		maxLatency  = 1;
		errorCount  = 0;
		testCount   = 0;
		failCount   = 0;
		applyReset();

		alignedCopyTest();
		dstAheadTest();
		dstBehindTest();
		forceMaskTest();
		randomCopyTest();
		handshakeTest();

		$display("tests run: %0d, failed: %0d, mismatches: %0d",
			testCount, failCount, errorCount);
		if (errorCount == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// Sized for the worst case of all tests
	initial begin
		#(WatchCycles * ClkPeriod);
		$display("watchdog expired before the tests finished");
		$display("Test failures found");
		$finish;
	end

endmodule

// ==== design/copyTop.sv ====
// Top level of the VRAM-to-VRAM rectangle copy engine
// Copy setup and start handshake in, block memory port out

`include "copy_params.svh"

module copyTop import vramGeomPkg::*, memBusPkg::*; (
	input  logic                   i_clk,
	input  logic                   i_rst,

	// Copy setup, stable while i_copyReq is high
	input  vramX_t                 i_srcX,
	input  vramY_t                 i_srcY,
	input  vramX_t                 i_dstX,
	input  vramY_t                 i_dstY,
	input  sizeW_t                 i_sizeW,
	input  sizeH_t                 i_sizeH,
	input  logic                   i_forceMask,

	// Four-phase start handshake
	input  logic                   i_copyReq,
	output logic                   o_copyAck,

	// ----------------------------------------
	// Memory port
	// ----------------------------------------
	output logic                   o_command,
	output logic                   o_write,
	output memAdr_t                o_adr,
	output pixMask_t               o_writeMask,
	output block_t                 o_dataOut,
	input  logic                   i_busy,
	input  logic [`BLOCK_BITS-1:0] i_dataIn,
	input  logic                   i_dataInValid
);

	shift_t       shift;
	block_t [1:0] window;

	memCmdIf cmdBus ();

	copySequencer sequencer (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_copyReq (i_copyReq),
		.o_copyAck (o_copyAck),
		.i_srcX    (i_srcX),
		.i_srcY    (i_srcY),
		.i_dstX    (i_dstX),
		.i_dstY    (i_dstY),
		.i_sizeW   (i_sizeW),
		.i_sizeH   (i_sizeH),
		.o_shift   (shift),
		.mem       (cmdBus.seq)
	);

	blockFetcher fetcher (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.mem           (cmdBus.fetch),
		.o_command     (o_command),
		.o_write       (o_write),
		.o_adr         (o_adr),
		.o_writeMask   (o_writeMask),
		.i_busy        (i_busy),
		.i_dataIn      (i_dataIn),
		.i_dataInValid (i_dataInValid),
		.o_window      (window)
	);

	// Write data follows the current window and shift
	windowRotator rotator (
		.i_window    (window),
		.i_shift     (shift),
		.i_forceMask (i_forceMask),
		.o_block     (o_dataOut)
	);

endmodule

// ==== design/copySequencer.sv ====
// Copy FSM for left-to-right VRAM rectangle copies
// Issues source reads and masked destination writes one block at a time

`include "copy_params.svh"

module copySequencer import vramGeomPkg::*, memBusPkg::*; (
	input  logic   i_clk,
	input  logic   i_rst,
	input  logic   i_copyReq,
	output logic   o_copyAck,
	input  vramX_t i_srcX,
	input  vramY_t i_srcY,
	input  vramX_t i_dstX,
	input  vramY_t i_dstY,
	input  sizeW_t i_sizeW,
	input  sizeH_t i_sizeH,
	output shift_t o_shift,
	memCmdIf.seq   mem
);

	localparam int CntBits = $bits(sizeW_t) - `BLOCK_IDX_BITS;  // Up to 65 blocks per line

	typedef enum logic [3:0] {
		S_IDLE, S_START_LINE, S_READ1, S_READ2, S_WRITE,
		S_READ, S_TAIL_W2, S_TAIL_W3, S_END_LINE, S_ACK
	} state_e;

	state_e               state;
	state_e               lineDone;
	vramX_t               srcX, dstX;
	vramY_t               srcY, dstY;
	sizeW_t               sizeW;
	sizeH_t               sizeH;
	sizeH_t               lineCnt;
	logic [CntBits-1:0]   srcCnt, dstCnt;
	logic                 fillBank;

	logic [`BLOCK_IDX_BITS-1:0] pixOffset;
	logic                 dblLoad, performSwitch;
	sizeW_t               srcEnd, dstEnd;
	logic                 isLastSrc, isLastDst, isLastLine;

	// ----------------------------------------
	// Line geometry
	// ----------------------------------------
	assign pixOffset     = srcX[`BLOCK_IDX_BITS-1:0] - dstX[`BLOCK_IDX_BITS-1:0];
	assign dblLoad       = dstX[`BLOCK_IDX_BITS-1:0] < srcX[`BLOCK_IDX_BITS-1:0];
	assign performSwitch = |pixOffset;  // Aligned copy stays in bank 0

	assign srcEnd = sizeW + sizeW_t'(srcX[`BLOCK_IDX_BITS-1:0]) - sizeW_t'(1);
	assign dstEnd = sizeW + sizeW_t'(dstX[`BLOCK_IDX_BITS-1:0]) - sizeW_t'(1);

	// Block count minus one of each side
	assign isLastSrc  = (srcCnt == srcEnd[$bits(sizeW_t)-1:`BLOCK_IDX_BITS]);
	assign isLastDst  = (dstCnt == dstEnd[$bits(sizeW_t)-1:`BLOCK_IDX_BITS]);
	assign isLastLine = (lineCnt == sizeH - sizeH_t'(1));
	assign lineDone   = isLastLine ? S_ACK : S_END_LINE;

	always_comb begin
		case (state)
			S_READ1, S_READ2, S_READ: mem.cmd = CMD_READ;
			S_WRITE, S_TAIL_W2, S_TAIL_W3: mem.cmd = CMD_WRITE;
			default: mem.cmd = CMD_IDLE;
		endcase
	end

	// Columns and lines wrap around the VRAM
	assign mem.adr = (mem.cmd == CMD_WRITE) ?
		{dstY + vramY_t'(lineCnt), blockX_t'(dstX >> `BLOCK_IDX_BITS) + blockX_t'(dstCnt)} :
		{srcY + vramY_t'(lineCnt), blockX_t'(srcX >> `BLOCK_IDX_BITS) + blockX_t'(srcCnt)};
	assign mem.bank = fillBank;

	edgeMaskGen edgeMask (
		.i_dstX     (dstX),
		.i_sizeW    (sizeW),
		.i_blockIdx (blockX_t'(dstCnt)),
		.o_mask     (mem.writeMask)
	);

	// Fill bank points at the older block once the reads are in
	assign o_shift   = '{bank: fillBank, offset: pixOffset};
	assign o_copyAck = (state == S_ACK);

	// Setup held for the whole copy
	always_ff @(posedge i_clk) begin
		if (state == S_IDLE && i_copyReq) begin
			srcX  <= i_srcX;
			srcY  <= i_srcY;
			dstX  <= i_dstX;
			dstY  <= i_dstY;
			sizeW <= i_sizeW;
			sizeH <= i_sizeH;
		end
	end

	// ----------------------------------------
	// State, counters and bank control
	// ----------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state    <= S_IDLE;
			lineCnt  <= '0;
			srcCnt   <= '0;
			dstCnt   <= '0;
			fillBank <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					lineCnt <= '0;
					if (i_copyReq)
						state <= S_START_LINE;
				end
				S_START_LINE: begin
					srcCnt   <= '0;
					dstCnt   <= '0;
					fillBank <= 1'b0;
					state    <= S_READ1;
				end
				S_READ1: begin
					if (mem.accepted) begin
						srcCnt <= srcCnt + 1'b1;
						// Lone block of a double load stays where the write expects it
						fillBank <= fillBank ^ (performSwitch && !(dblLoad && isLastSrc));
						if (isLastSrc)
							state <= S_TAIL_W2;
						else if (dblLoad)
							state <= S_READ2;
						else
							state <= S_WRITE;
					end
				end
				S_READ2, S_READ: begin
					if (mem.accepted) begin
						srcCnt   <= srcCnt + 1'b1;
						fillBank <= fillBank ^ performSwitch;
						state    <= isLastSrc ? S_TAIL_W2 : S_WRITE;
					end
				end
				S_WRITE: begin
					if (mem.accepted) begin
						dstCnt <= dstCnt + 1'b1;
						state  <= S_READ;
					end
				end
				S_TAIL_W2: begin
					if (mem.accepted) begin
						dstCnt   <= dstCnt + 1'b1;
						fillBank <= fillBank ^ performSwitch;  // Last block moves to the low half
						state    <= isLastDst ? lineDone : S_TAIL_W3;
					end
				end
				S_TAIL_W3: begin
					if (mem.accepted)
						state <= lineDone;
				end
				S_END_LINE: begin
					lineCnt <= lineCnt + 1'b1;
					state   <= S_START_LINE;
				end
				S_ACK: begin
					if (!i_copyReq)
						state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// ==== design/blockFetcher.sv ====
// Memory port side of the copy engine
// Holds back commands while a read is in flight and fills the two-bank read cache

`include "copy_params.svh"

module blockFetcher import vramGeomPkg::*, memBusPkg::*; (
	input  logic                   i_clk,
	input  logic                   i_rst,
	memCmdIf.fetch                 mem,

	// Memory port
	output logic                   o_command,
	output logic                   o_write,
	output memAdr_t                o_adr,
	output pixMask_t               o_writeMask,
	input  logic                   i_busy,
	input  logic [`BLOCK_BITS-1:0] i_dataIn,
	input  logic                   i_dataInValid,

	// Read cache, bank 0 in the low half
	output block_t [1:0]           o_window
);

	logic readPending;  // One read outstanding at most
	logic pendingBank;
	logic readAccept;

	// ----------------------------------------
	// Command handshake
	// ----------------------------------------
	assign o_command   = (mem.cmd != CMD_IDLE) && !readPending;
	assign o_write     = (mem.cmd == CMD_WRITE);
	assign o_adr       = mem.adr;
	assign o_writeMask = mem.writeMask;

	assign mem.accepted = o_command && !i_busy;
	assign readAccept   = mem.accepted && (mem.cmd == CMD_READ);

	always_ff @(posedge i_clk) begin
		if (i_rst)
			readPending <= 1'b0;
		else if (readAccept)
			readPending <= 1'b1;
		else if (i_dataInValid)
			readPending <= 1'b0;  // Next command goes out with the bank updated
	end

	// ----------------------------------------
	// Read cache
	// ----------------------------------------
	always_ff @(posedge i_clk) begin
		if (readAccept)
			pendingBank <= mem.bank;  // Where the returning block lands
		if (readPending && i_dataInValid)
			o_window[pendingBank] <= i_dataIn;
	end

endmodule

// ==== design/windowRotator.sv ====
// Picks the 16 destination-aligned pixels out of the two-bank window
// Also forces the mask bit of every written pixel when asked

`include "copy_params.svh"

module windowRotator import vramGeomPkg::*; (
	input  block_t [1:0] i_window,
	input  shift_t       i_shift,
	input  logic         i_forceMask,
	output block_t       o_block
);

	always_comb begin
		pixel_t [2*`PIXELS_PER_BLOCK-1:0] win;
		logic [`BLOCK_IDX_BITS:0]         selIdx;
		pixel_t                           pix;

		// Older block goes to the low half
		win = i_shift.bank ? {i_window[0], i_window[1]} : i_window;

		for (int p = 0; p < `PIXELS_PER_BLOCK; p++) begin
			selIdx      = {1'b0, p[`BLOCK_IDX_BITS-1:0]} + {1'b0, i_shift.offset};
			pix         = win[selIdx];
			pix.maskBit = pix.maskBit | i_forceMask;  // Bit 15 set on request
			o_block[p]  = pix;
		end
	end

endmodule

// ==== design/edgeMaskGen.sv ====
// Write mask of one destination block
// Enables only the pixels that fall inside [x1, x1+W) of the current line

`include "copy_params.svh"

module edgeMaskGen import vramGeomPkg::*, memBusPkg::*; (
	input  vramX_t   i_dstX,
	input  sizeW_t   i_sizeW,
	input  blockX_t  i_blockIdx,  // Block count from the line start
	output pixMask_t o_mask
);

	sizeW_t                     endPos;
	logic [`BLOCK_IDX_BITS-1:0] firstPix;
	logic [`BLOCK_IDX_BITS-1:0] lastPix;
	logic                       isFirst;
	logic                       isLast;

	// Last pixel relative to the first destination block
	assign endPos   = sizeW_t'(i_dstX[`BLOCK_IDX_BITS-1:0]) + i_sizeW - sizeW_t'(1);
	assign firstPix = i_dstX[`BLOCK_IDX_BITS-1:0];
	assign lastPix  = endPos[`BLOCK_IDX_BITS-1:0];

	assign isFirst = (i_blockIdx == '0);
	assign isLast  = (i_blockIdx == blockX_t'(endPos >> `BLOCK_IDX_BITS));

	// Single block lines get both edges
	always_comb begin
		logic [`BLOCK_IDX_BITS-1:0] pixIdx;
		for (int p = 0; p < `PIXELS_PER_BLOCK; p++) begin
			pixIdx    = p[`BLOCK_IDX_BITS-1:0];
			o_mask[p] = (!isFirst || (pixIdx >= firstPix)) &&
				(!isLast || (pixIdx <= lastPix));
		end
	end

endmodule

// ==== design/memCmdIf.sv ====
// Command path between the copy sequencer and the block fetcher
// The fetcher pulses accepted when the memory port takes the command

interface memCmdIf import memBusPkg::*; ();

	memCmd_e  cmd;        // Requested access
	memAdr_t  adr;        // Block address
	pixMask_t writeMask;  // Pixel enables of a write
	logic     bank;       // Bank that a read fills
	logic     accepted;   // One cycle, command taken

	// ----------------------------------------
	// Sequencer side
	// ----------------------------------------
	modport seq (
		output cmd,
		output adr,
		output writeMask,
		output bank,
		input  accepted
	);

	// ----------------------------------------
	// Fetcher side
	// ----------------------------------------
	modport fetch (
		input  cmd,
		input  adr,
		input  writeMask,
		input  bank,
		output accepted
	);

endinterface

// ==== design/memBusPkg.sv ====
// Types of the block memory port
// Shared by the sequencer, the fetcher and the top level

`include "copy_params.svh"

package memBusPkg;

	// Line in the high bits, block column in the low bits
	typedef logic [$clog2(`VRAM_HEIGHT) + $clog2(`VRAM_WIDTH / `PIXELS_PER_BLOCK)-1:0] memAdr_t;

	// One write enable per pixel of a block
	typedef logic [`PIXELS_PER_BLOCK-1:0] pixMask_t;

	typedef enum logic [1:0] {
		CMD_IDLE  = 2'd0,
		CMD_READ  = 2'd1,
		CMD_WRITE = 2'd2
	} memCmd_e;

endpackage

// ==== design/vramGeomPkg.sv ====
// Pixel, block and coordinate types for the video memory
// Imported by every module that handles pixels or rectangle geometry

`include "copy_params.svh"

package vramGeomPkg;

	// One 16-bit pixel, mask bit on top
	typedef struct packed {
		logic        maskBit;
		logic [14:0] color;
	} pixel_t;

	// Pixel 0 sits in the low bits
	typedef pixel_t [`PIXELS_PER_BLOCK-1:0] block_t;

	// ----------------------------------------
	// Coordinates and sizes
	// ----------------------------------------
	typedef logic [$clog2(`VRAM_WIDTH)-1:0] vramX_t;
	typedef logic [$clog2(`VRAM_HEIGHT)-1:0] vramY_t;
	typedef logic [$clog2(`VRAM_WIDTH / `PIXELS_PER_BLOCK)-1:0] blockX_t;
	typedef logic [$clog2(`VRAM_WIDTH):0] sizeW_t;   // 1 to 1024
	typedef logic [$clog2(`VRAM_HEIGHT):0] sizeH_t;  // 1 to 512

	// Window rotation applied to the two read banks
	typedef struct packed {
		logic                       bank;    // Swap the banks first
		logic [`BLOCK_IDX_BITS-1:0] offset;  // First pixel taken
	} shift_t;

endpackage

// ==== design/copy_params.svh ====
// Geometry constants for the VRAM copy engine
// Included by the packages and by any module that slices pixel or block fields

`ifndef COPY_PARAMS_SVH
`define COPY_PARAMS_SVH

// ----------------------------------------
// Memory block layout
// ----------------------------------------

// Pixels moved by one memory access
`define PIXELS_PER_BLOCK 16

// Pixel index inside a block
`define BLOCK_IDX_BITS 4

// Data width of one block, 16 bits per pixel
`define BLOCK_BITS 256

// ----------------------------------------
// Video memory size
// ----------------------------------------

`define VRAM_WIDTH 1024  // Pixels per line
`define VRAM_HEIGHT 512  // Lines

`endif
